/* compile.f */
src/aswb_pkg.sv
src/aswb_cmd_decoder.sv
src/aswb_wb_master.sv
src/aswb_reply_serializer.sv
src/aswb_wb_ram.sv
src/aswb_top.sv
verif/aswb_assertions.sv
verif/aswb_tb.sv

/* Bender.yml */
package:
  name: aswb

sources:
  - src/aswb_pkg.sv
  - src/aswb_cmd_decoder.sv
  - src/aswb_wb_master.sv
  - src/aswb_reply_serializer.sv
  - src/aswb_wb_ram.sv
  - src/aswb_top.sv
  - target: test
    files:
      - verif/aswb_assertions.sv
      - verif/aswb_tb.sv

/* verif/aswb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module aswb_tb;

  localparam int     N_OOR        = 40;
  localparam int     N_MIX        = 200;
  localparam int     CMD_CYCLES   = 40;  // cycles per command with junk bytes and stalls included
  localparam int     DRAIN_CYCLES = 4 * CMD_CYCLES;  // at most three replies are still in flight
  localparam integer SEED         = 32'h0e3875e2;

  logic            clk = 1'b0;
  logic            reset;
  logic            rx_valid_i;
  aswb_pkg::byte_t rx_data_i;
  logic            rx_ready_o;
  logic            tx_valid_o;
  aswb_pkg::byte_t tx_data_o;
  logic            tx_ready_i;

  integer          stim_seed  = SEED;
  integer          stall_seed = SEED;
  int              ram_words;
  int              sent = 0;
  int              done = 0;
  aswb_pkg::data_t model_mem [int];
  aswb_pkg::byte_t exp_status [$];
  bit              exp_read [$];  // a good read is followed by two data bytes
  aswb_pkg::data_t exp_word [$];

  aswb_top uut (
    .clk        (clk),
    .reset      (reset),
    .rx_valid_i (rx_valid_i),
    .rx_data_i  (rx_data_i),
    .rx_ready_o (rx_ready_o),
    .tx_valid_o (tx_valid_o),
    .tx_data_o  (tx_data_o),
    .tx_ready_i (tx_ready_i)
  );

  always #50 clk = ~clk;

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_byte(input aswb_pkg::byte_t got, input aswb_pkg::byte_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: status byte expected %02h, received %02h", $time, exp, got);
      stop_with_failure();
    end
  endtask

  task automatic check_word(input aswb_pkg::data_t got, input aswb_pkg::data_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: read word expected %04h, received %04h", $time, exp, got);
      stop_with_failure();
    end
  endtask

  function automatic aswb_pkg::addr_t valid_adr();
    return $unsigned($random(stim_seed)) % ram_words;
  endfunction

  function automatic aswb_pkg::addr_t oor_adr();
    return ram_words + $unsigned($random(stim_seed)) % (65536 - ram_words);
  endfunction

  // the byte is offered right away and counts as taken on the edge after a high ready
  task automatic send_byte(input aswb_pkg::byte_t b);
    logic taken;
    taken      = 1'b0;
    rx_valid_i = 1'b1;
    rx_data_i  = b;
    while (!taken) begin
      @(negedge clk);
      taken = rx_ready_o;
      @(posedge clk);
      #1;
    end
    rx_valid_i = 1'b0;
  endtask

  task automatic run_cmd(input bit we, input aswb_pkg::addr_t adr, input aswb_pkg::data_t dat);
    bit              ok;
    aswb_pkg::byte_t junk;
    ok = (adr < ram_words);
    exp_status.push_back(ok ? aswb_pkg::STATUS_OK : aswb_pkg::STATUS_ERR);
    exp_read.push_back(ok && !we);
    if (ok && we) begin
      model_mem[adr] = dat;
    end else if (ok) begin
      exp_word.push_back(model_mem[adr]);
    end
    sent++;
    repeat ($unsigned($random(stim_seed)) % 3) begin  // nop or unknown bytes before the command
      junk = $random(stim_seed);
      send_byte((junk == aswb_pkg::CMD_READ || junk == aswb_pkg::CMD_WRITE) ?
                aswb_pkg::CMD_NOP : junk);
    end
    send_byte(we ? aswb_pkg::CMD_WRITE : aswb_pkg::CMD_READ);
    send_byte(adr[7:0]);
    send_byte(adr[15:8]);
    if (we) begin
      send_byte(dat[7:0]);
      send_byte(dat[15:8]);
    end
  endtask

  task automatic read_all_shuffled();
    int order [];
    int j;
    int t;
    order = new[ram_words];
    foreach (order[i]) order[i] = i;
    for (int i = ram_words - 1; i > 0; i--) begin
      j        = $unsigned($random(stim_seed)) % (i + 1);
      t        = order[i];
      order[i] = order[j];
      order[j] = t;
    end
    foreach (order[i]) run_cmd(1'b0, order[i], '0);
  endtask

  task automatic get_byte(output aswb_pkg::byte_t b);
    bit got;
    got = 1'b0;
    while (!got) begin
      @(posedge clk);
      #1;
      tx_ready_i = ($random(stall_seed) & 3) != 0;  // stall about one cycle in four
      @(negedge clk);
      got = tx_valid_o && tx_ready_i;
      b   = tx_data_o;
    end
  endtask

  initial begin : collect
    aswb_pkg::byte_t b;
    aswb_pkg::byte_t lo;
    aswb_pkg::byte_t hi;
    forever begin
      get_byte(b);
      if (exp_status.size() == 0) begin
        $display("A reply byte %02h arrived at %0t ns with no command pending", b, $time);
        stop_with_failure();
      end else begin
        check_byte(b, exp_status.pop_front());
        if (exp_read.pop_front()) begin
          get_byte(lo);
          get_byte(hi);
          check_word({hi, lo}, exp_word.pop_front());
        end
        done++;
      end
    end
  end

  initial begin : main
    aswb_pkg::addr_t adr;
    int              idle;
    reset      = 1'b1;
    rx_valid_i = 1'b0;
    rx_data_i  = '0;
    tx_ready_i = 1'b0;
    ram_words  = uut.RAM_WORDS;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int a = 0; a < ram_words; a++) begin
      run_cmd(1'b1, a, $random(stim_seed));
    end
    read_all_shuffled();
    repeat (N_OOR) begin
      adr = oor_adr();
      run_cmd($random(stim_seed) & 1, adr, $random(stim_seed));
    end
    read_all_shuffled();  // out-of-range writes must not have touched any word
    repeat (N_MIX) begin
      adr = (($random(stim_seed) & 7) != 0) ? valid_adr() : oor_adr();
      run_cmd($random(stim_seed) & 1, adr, $random(stim_seed));
    end
    idle = 0;
    while (done != sent && idle < DRAIN_CYCLES) begin
      @(posedge clk);
      idle++;
    end
    repeat (20) @(posedge clk);
    if (done != sent || exp_status.size() != 0 || exp_word.size() != 0) begin
      $display("Expected reply bytes were still outstanding at the end of the run");
      stop_with_failure();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  initial begin : watchdog
    longint limit;
    @(negedge reset);
    limit = (3 * ram_words + N_OOR + N_MIX) * CMD_CYCLES * 2;
    repeat (limit) @(posedge clk);
    $display("Timeout: the replies did not complete within %0d cycles", limit);
    stop_with_failure();
  end

endmodule

`default_nettype wire

/* verif/aswb_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module aswb_assertions (
  input wire                  clk,
  input wire                  reset,
  input wire                  wb_cyc,
  input wire                  wb_stb,
  input wire                  wb_we,
  input wire aswb_pkg::addr_t wb_adr,
  input wire aswb_pkg::data_t wb_dat_w,
  input wire                  wb_ack,
  input wire                  wb_err,
  input wire                  rsp_valid,
  input wire                  rx_ready_o,
  input wire                  tx_valid_o,
  input wire aswb_pkg::byte_t tx_data_o,
  input wire                  tx_ready_i
);

  stb_follows_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb == wb_cyc)
    else $error("wishbone stb differs from cyc");

  wb_held: assert property (@(posedge clk) disable iff (reset)
    wb_cyc && !(wb_ack || wb_err) |=> wb_cyc && $stable({wb_we, wb_adr, wb_dat_w}))
    else $error("wishbone master outputs changed before ack or err");

  ack_err_exclusive: assert property (@(posedge clk) disable iff (reset) !(wb_ack && wb_err))
    else $error("wishbone ack and err high together");

  tx_held: assert property (@(posedge clk) disable iff (reset)
    tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o))
    else $error("tx byte dropped or changed while stalled");

  reset_values: assert property (@(posedge clk)
    reset |=> !wb_cyc && !rsp_valid && !tx_valid_o && rx_ready_o)
    else $error("wrong values after reset");

endmodule

bind aswb_top aswb_assertions u_assertions (.*);

`default_nettype wire

/* src/aswb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module aswb_top #(
  parameter int RAM_WORDS   = 64,
  parameter int WAIT_STATES = 2
) (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    rx_valid_i,
  input  wire  aswb_pkg::byte_t  rx_data_i,
  output logic                   rx_ready_o,
  output logic                   tx_valid_o,
  output aswb_pkg::byte_t        tx_data_o,
  input  wire                    tx_ready_i
);

  logic            req_valid;
  logic            req_ready;
  logic            req_we;
  aswb_pkg::addr_t req_adr;
  aswb_pkg::data_t req_dat;

  logic            wb_cyc;
  logic            wb_stb;
  logic            wb_we;
  aswb_pkg::addr_t wb_adr;
  aswb_pkg::data_t wb_dat_w;
  aswb_pkg::data_t wb_dat_r;
  logic            wb_ack;
  logic            wb_err;

  logic            rsp_valid;
  logic            rsp_ready;
  logic            rsp_err;
  logic            rsp_we;
  aswb_pkg::data_t rsp_dat;

  aswb_cmd_decoder u_decoder (
    .clk         (clk),
    .reset       (reset),
    .rx_valid_i  (rx_valid_i),
    .rx_data_i   (rx_data_i),
    .rx_ready_o  (rx_ready_o),
    .req_valid_o (req_valid),
    .req_we_o    (req_we),
    .req_adr_o   (req_adr),
    .req_dat_o   (req_dat),
    .req_ready_i (req_ready)
  );

  aswb_wb_master u_master (
    .clk         (clk),
    .reset       (reset),
    .req_valid_i (req_valid),
    .req_we_i    (req_we),
    .req_adr_i   (req_adr),
    .req_dat_i   (req_dat),
    .req_ready_o (req_ready),
    .wb_cyc_o    (wb_cyc),
    .wb_stb_o    (wb_stb),
    .wb_we_o     (wb_we),
    .wb_adr_o    (wb_adr),
    .wb_dat_o    (wb_dat_w),
    .wb_dat_i    (wb_dat_r),
    .wb_ack_i    (wb_ack),
    .wb_err_i    (wb_err),
    .rsp_valid_o (rsp_valid),
    .rsp_err_o   (rsp_err),
    .rsp_we_o    (rsp_we),
    .rsp_dat_o   (rsp_dat),
    .rsp_ready_i (rsp_ready)
  );

  aswb_reply_serializer u_serializer (
    .clk         (clk),
    .reset       (reset),
    .rsp_valid_i (rsp_valid),
    .rsp_err_i   (rsp_err),
    .rsp_we_i    (rsp_we),
    .rsp_dat_i   (rsp_dat),
    .rsp_ready_o (rsp_ready),
    .tx_valid_o  (tx_valid_o),
    .tx_data_o   (tx_data_o),
    .tx_ready_i  (tx_ready_i)
  );

  aswb_wb_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) u_ram (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err)
  );

endmodule

`default_nettype wire

/* src/aswb_wb_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module aswb_wb_ram #(
  parameter int RAM_WORDS   = 64,
  parameter int WAIT_STATES = 2
) (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    wb_cyc_i,
  input  wire                    wb_stb_i,
  input  wire                    wb_we_i,
  input  wire  aswb_pkg::addr_t  wb_adr_i,
  input  wire  aswb_pkg::data_t  wb_dat_i,
  output aswb_pkg::data_t        wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   wb_err_o
);

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int CNT_W = $clog2(WAIT_STATES + 1);

  aswb_pkg::data_t mem [RAM_WORDS];
  logic [CNT_W-1:0] wait_cnt;
  logic             pending;
  logic             respond;
  logic             in_range;

  // WAIT_STATES must be at least one, the reply is a registered pulse
  assign pending  = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;
  assign respond  = pending & (wait_cnt == CNT_W'(WAIT_STATES - 1));
  assign in_range = (wb_adr_i < RAM_WORDS);

  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt <= '0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= respond & in_range;
      wb_err_o <= respond & ~in_range;
      if (pending && !respond) begin
        wait_cnt <= wait_cnt + 1'b1;
      end else begin
        wait_cnt <= '0;  // rearm for the next strobe
      end
    end
  end

  always_ff @(posedge clk) begin
    if (respond && in_range) begin
      if (wb_we_i) begin
        mem[wb_adr_i[IDX_W-1:0]] <= wb_dat_i;
      end
      wb_dat_o <= mem[wb_adr_i[IDX_W-1:0]];  // valid during the ack cycle
    end
  end

endmodule

`default_nettype wire

/* src/aswb_reply_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module aswb_reply_serializer (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    rsp_valid_i,
  input  wire                    rsp_err_i,
  input  wire                    rsp_we_i,
  input  wire  aswb_pkg::data_t  rsp_dat_i,
  output logic                   rsp_ready_o,
  output logic                   tx_valid_o,
  output aswb_pkg::byte_t        tx_data_o,
  input  wire                    tx_ready_i
);

  logic            rsp_fire;
  logic            tx_fire;
  logic [1:0]      byte_cnt;
  logic [1:0]      byte_last;  // index of the final reply byte
  aswb_pkg::data_t word;

  assign rsp_ready_o = ~tx_valid_o;
  assign rsp_fire    = rsp_valid_i & rsp_ready_o;
  assign tx_fire     = tx_valid_o & tx_ready_i;

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_valid_o <= 1'b0;
      byte_cnt   <= 2'd0;
    end else if (rsp_fire) begin
      tx_valid_o <= 1'b1;
      byte_cnt   <= 2'd0;
    end else if (tx_fire) begin
      if (byte_cnt == byte_last) begin
        tx_valid_o <= 1'b0;
      end else begin
        byte_cnt <= byte_cnt + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_fire) begin
      tx_data_o <= rsp_err_i ? aswb_pkg::STATUS_ERR : aswb_pkg::STATUS_OK;
      word      <= rsp_dat_i;
      byte_last <= (rsp_err_i || rsp_we_i) ? 2'd0 : 2'd2;  // good reads add two data bytes
    end else if (tx_fire && byte_cnt != byte_last) begin
      tx_data_o <= (byte_cnt == 2'd0) ? word[7:0] : word[15:8];
    end
  end

endmodule

`default_nettype wire

/* src/aswb_wb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module aswb_wb_master (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    req_valid_i,
  input  wire                    req_we_i,
  input  wire  aswb_pkg::addr_t  req_adr_i,
  input  wire  aswb_pkg::data_t  req_dat_i,
  output logic                   req_ready_o,
  output logic                   wb_cyc_o,
  output logic                   wb_stb_o,
  output logic                   wb_we_o,
  output aswb_pkg::addr_t        wb_adr_o,
  output aswb_pkg::data_t        wb_dat_o,
  input  wire  aswb_pkg::data_t  wb_dat_i,
  input  wire                    wb_ack_i,
  input  wire                    wb_err_i,
  output logic                   rsp_valid_o,
  output logic                   rsp_err_o,
  output logic                   rsp_we_o,
  output aswb_pkg::data_t        rsp_dat_o,
  input  wire                    rsp_ready_i
);

  logic req_fire;
  logic wb_done;

  assign req_ready_o = ~wb_cyc_o & ~rsp_valid_o;  // one transfer or result at a time
  assign wb_stb_o    = wb_cyc_o;
  assign req_fire    = req_valid_i & req_ready_o;
  assign wb_done     = wb_cyc_o & (wb_ack_i | wb_err_i);

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_cyc_o    <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      if (req_fire) begin
        wb_cyc_o <= 1'b1;
      end else if (wb_done) begin
        wb_cyc_o <= 1'b0;  // classic cycle ends the cycle after ack or err
      end
      if (wb_done) begin
        rsp_valid_o <= 1'b1;
      end else if (rsp_valid_o && rsp_ready_i) begin
        rsp_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      wb_we_o  <= req_we_i;
      wb_adr_o <= req_adr_i;
      wb_dat_o <= req_dat_i;
    end
    if (wb_done) begin
      rsp_err_o <= wb_err_i;
      rsp_we_o  <= wb_we_o;
    end
    if (wb_cyc_o && wb_ack_i) begin
      rsp_dat_o <= wb_dat_i;
    end
  end

endmodule

`default_nettype wire

/* src/aswb_cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module aswb_cmd_decoder (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    rx_valid_i,
  input  wire  aswb_pkg::byte_t  rx_data_i,
  output logic                   rx_ready_o,
  output logic                   req_valid_o,
  output logic                   req_we_o,
  output aswb_pkg::addr_t        req_adr_o,
  output aswb_pkg::data_t        req_dat_o,
  input  wire                    req_ready_i
);

  typedef enum logic [2:0] {
    ST_CMD,
    ST_ADR_LO,
    ST_ADR_HI,
    ST_DAT_LO,
    ST_DAT_HI
  } state_t;

  state_t state;
  logic   rx_fire;
  logic   req_fire;
  logic   last_byte;

  // stall only while a finished request waits for the master
  assign rx_ready_o = ~req_valid_o | req_ready_i;
  assign rx_fire    = rx_valid_i & rx_ready_o;
  assign req_fire   = req_valid_o & req_ready_i;

  assign last_byte = rx_fire & ((state == ST_ADR_HI && !req_we_o) || state == ST_DAT_HI);

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ST_CMD;
      req_valid_o <= 1'b0;
    end else begin
      if (req_fire) begin
        req_valid_o <= 1'b0;
      end
      if (last_byte) begin
        req_valid_o <= 1'b1;  // wins over a same-cycle hand-off
      end
      if (rx_fire) begin
        case (state)
          ST_CMD: begin
            if (rx_data_i == aswb_pkg::CMD_READ || rx_data_i == aswb_pkg::CMD_WRITE) begin
              state <= ST_ADR_LO;
            end
          end
          ST_ADR_LO: state <= ST_ADR_HI;
          ST_ADR_HI: state <= req_we_o ? ST_DAT_LO : ST_CMD;  // reads carry no data
          ST_DAT_LO: state <= ST_DAT_HI;
          default:   state <= ST_CMD;
        endcase
      end
    end
  end

  // request fields fill in place, they only change once the held request is taken
  always_ff @(posedge clk) begin
    if (rx_fire) begin
      case (state)
        ST_CMD:    req_we_o        <= (rx_data_i == aswb_pkg::CMD_WRITE);
        ST_ADR_LO: req_adr_o[7:0]  <= rx_data_i;
        ST_ADR_HI: req_adr_o[15:8] <= rx_data_i;
        ST_DAT_LO: req_dat_o[7:0]  <= rx_data_i;
        default:   req_dat_o[15:8] <= rx_data_i;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/aswb_pkg.sv */
`default_nettype none

package aswb_pkg;

  localparam int ADDR_W = 16;  // wishbone word address width
  localparam int DATA_W = 16;  // wishbone data width

  typedef logic [7:0]        byte_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // command bytes, anything else is skipped like a nop
  localparam byte_t CMD_NOP   = 8'h00;
  localparam byte_t CMD_READ  = 8'h01;
  localparam byte_t CMD_WRITE = 8'h02;

  localparam byte_t STATUS_OK  = 8'h00;  // first byte of every reply
  localparam byte_t STATUS_ERR = 8'hee;

endpackage

`default_nettype wire
